// ==== simd_polar_alu.f ====
+incdir+dv
verilog/alu_pkg.sv
verilog/int_adder_cmp.sv
verilog/int_shifter.sv
verilog/polar_simd_unit.sv
verilog/alu_result_stage.sv
verilog/simd_polar_alu.sv
dv/tb_simd_polar_alu.sv

// ==== Makefile ====
TOP := tb_simd_polar_alu

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f simd_polar_alu.f \
		--top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
		echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

// ==== dv/tb_ref_model.svh ====
// ------------------------------
// Reference model: expected response of a request,
// lane helpers for the polar ops
// ------------------------------

`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Clamp to the symmetric lane range
function automatic int clamp_lane(input int v);
    if (v > alu_pkg::LANE_SAT_MAX) begin
        return alu_pkg::LANE_SAT_MAX;
    end
    if (v < -alu_pkg::LANE_SAT_MAX) begin
        return -alu_pkg::LANE_SAT_MAX;
    end
    return v;
endfunction

// One signed lane of a polar op
function automatic alu_pkg::lane_t lane_result(input alu_pkg::alu_op_e op, input int a,
                                               input int b);
    int mag_a;
    int mag_b;
    int m;
    int r;
    // |-128| lands on 127 through the clamp
    mag_a = clamp_lane((a < 0) ? -a : a);
    mag_b = clamp_lane((b < 0) ? -b : b);
    m     = (mag_a > mag_b) ? mag_b : mag_a;
    case (op)
        alu_pkg::PL_R:      r = (a < 0 && b != 1) ? 1 : 0;
        alu_pkg::PL_F:      r = ((a < 0) != (b < 0)) ? -m : m;
        alu_pkg::PL_SUBSAT: r = clamp_lane(a - b);
        alu_pkg::PL_ADDSAT: r = clamp_lane(a + b);
        alu_pkg::PL_DECODE: r = (b == 0) ? a : 0;
        alu_pkg::PL_EVAL:   r = (a == 1) ? -1 : 0;
        default:            r = 0;
    endcase
    return alu_pkg::lane_t'(r);
endfunction

function automatic alu_pkg::xlen_t widen_word(input alu_pkg::word_t w);
    return alu_pkg::xlen_t'($signed(w));
endfunction

function automatic alu_pkg::alu_rsp_t expected_rsp(input alu_pkg::alu_req_t req);
    alu_pkg::alu_rsp_t rsp;
    alu_pkg::xlen_t    a;
    alu_pkg::xlen_t    b;
    alu_pkg::word_t    aw;
    int unsigned       sh;
    int unsigned       shw;
    logic              lt_s;
    logic              lt_u;
    a    = req.operand_a;
    b    = req.operand_b;
    aw   = a[31:0];
    sh   = b[5:0];
    shw  = b[4:0];
    lt_s = $signed(a) < $signed(b);
    lt_u = a < b;
    rsp.result       = '0;
    rsp.branch_taken = 1'b1;
    case (req.op)
        alu_pkg::ADD:  rsp.result = a + b;
        alu_pkg::SUB:  rsp.result = a - b;
        alu_pkg::ADDW: rsp.result = widen_word(aw + b[31:0]);
        alu_pkg::SUBW: rsp.result = widen_word(aw - b[31:0]);
        alu_pkg::ANDL: rsp.result = a & b;
        alu_pkg::ORL:  rsp.result = a | b;
        alu_pkg::XORL: rsp.result = a ^ b;
        alu_pkg::ANDN: rsp.result = a & ~b;
        alu_pkg::ORN:  rsp.result = a | ~b;
        alu_pkg::XNOR: rsp.result = ~(a ^ b);
        alu_pkg::SLL:  rsp.result = a << sh;
        alu_pkg::SRL:  rsp.result = a >> sh;
        alu_pkg::SRA:  rsp.result = $signed(a) >>> sh;
        alu_pkg::SLLW: rsp.result = widen_word(aw << shw);
        alu_pkg::SRLW: rsp.result = widen_word(aw >> shw);
        alu_pkg::SRAW: rsp.result = widen_word($signed(aw) >>> shw);
        alu_pkg::SLTS: rsp.result = {63'd0, lt_s};
        alu_pkg::SLTU: rsp.result = {63'd0, lt_u};
        alu_pkg::EQ:   rsp.branch_taken = (a == b);
        alu_pkg::NE:   rsp.branch_taken = (a != b);
        alu_pkg::LTS:  rsp.branch_taken = lt_s;
        alu_pkg::LTU:  rsp.branch_taken = lt_u;
        alu_pkg::GES:  rsp.branch_taken = !lt_s;
        alu_pkg::GEU:  rsp.branch_taken = !lt_u;
        default: begin
            for (int i = 0; i < alu_pkg::NUM_LANES; i++) begin
                rsp.result[i*alu_pkg::LANE_W +: alu_pkg::LANE_W] = lane_result(req.op,
                    $signed(a[i*alu_pkg::LANE_W +: alu_pkg::LANE_W]),
                    $signed(b[i*alu_pkg::LANE_W +: alu_pkg::LANE_W]));
            end
        end
    endcase
    return rsp;
endfunction

`endif

// ==== dv/tb_simd_polar_alu.sv ====
// ------------------------------
// Testbench for the SIMD polar ALU: clock, reset,
// random and edge stimulus, scoreboard, assertions
// ------------------------------

`timescale 1ns/10ps

module tb_simd_polar_alu;

    localparam int NUM_GROUPS     = 6;
    localparam int REQS_PER_GROUP = 200;
    // Stalls at most triple the request count, rest is margin
    localparam int MAX_CYCLES     = NUM_GROUPS * REQS_PER_GROUP * 5;

    typedef struct packed {
        logic [2:0]        group;
        alu_pkg::alu_rsp_t rsp;
    } exp_entry_t;

    logic              clk_i;
    logic              rst_n_i;
    alu_pkg::alu_req_t req_i;
    logic              in_valid_i;
    logic              in_ready_o;
    alu_pkg::alu_rsp_t rsp_o;
    logic              out_valid_o;
    logic              out_ready_i;

    int                seed;
    int                ready_seed;
    int                cycle_cnt;
    logic [2:0]        cur_group;
    logic              heavy_stall;
    exp_entry_t        exp_q[$];
    exp_entry_t        exp_head;
    int                exp_count;
    string             group_name [NUM_GROUPS];

    simd_polar_alu i_dut (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_i       (req_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .rsp_o       (rsp_o),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i)
    );

    `include "tb_ref_model.svh"

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic report_mismatch(input exp_entry_t e, input alu_pkg::alu_rsp_t act);
        report_failure($sformatf("Mismatch in %s: expected %h/%b, actual %h/%b",
            group_name[e.group], e.rsp.result, e.rsp.branch_taken,
            act.result, act.branch_taken));
    endtask

    // ------------------------------
    // Stimulus helpers
    // ------------------------------
    // Lane edges 0, +-1, +-127, -128
    function automatic alu_pkg::lane_t edge_lane();
        case ($unsigned($random(seed)) % 6)
            0:       return 8'h00;
            1:       return 8'h01;
            2:       return 8'hff;
            3:       return 8'h7f;
            4:       return 8'h81;
            default: return 8'h80;
        endcase
    endfunction

    function automatic alu_pkg::xlen_t pick_operand();
        alu_pkg::xlen_t v;
        case ($unsigned($random(seed)) % 8)
            0:       v = '0;
            1:       v = 64'd1;
            2:       v = '1;
            3:       v = {alu_pkg::NUM_LANES{8'h80}};
            4:       v = {alu_pkg::NUM_LANES{8'h7f}};
            5, 6: begin
                for (int i = 0; i < alu_pkg::NUM_LANES; i++) begin
                    v[i*alu_pkg::LANE_W +: alu_pkg::LANE_W] = edge_lane();
                end
            end
            default: v = {$random(seed), $random(seed)};
        endcase
        return v;
    endfunction

    // Random upper bits check that only the low amount bits count
    function automatic alu_pkg::xlen_t pick_shamt();
        alu_pkg::xlen_t v;
        v = {$random(seed), $random(seed)};
        case ($unsigned($random(seed)) % 6)
            0:       v[5:0] = 6'd0;
            1:       v[5:0] = 6'd31;
            2:       v[5:0] = 6'd32;
            3:       v[5:0] = 6'd63;
            default: v[5:0] = v[5:0];
        endcase
        return v;
    endfunction

    function automatic alu_pkg::alu_op_e pick_op(input int group);
        int r;
        r = $unsigned($random(seed)) % 30;
        case (group)
            0: return alu_pkg::alu_op_e'(alu_pkg::ADD + r % 10);
            1: return alu_pkg::alu_op_e'(alu_pkg::SLL + r % 6);
            2: return alu_pkg::alu_op_e'(alu_pkg::SLTS + r % 8);
            3: return (r % 2) ? alu_pkg::PL_ADDSAT : alu_pkg::PL_SUBSAT;
            4: begin
                case (r % 4)
                    0:       return alu_pkg::PL_R;
                    1:       return alu_pkg::PL_F;
                    2:       return alu_pkg::PL_DECODE;
                    default: return alu_pkg::PL_EVAL;
                endcase
            end
            default: return alu_pkg::alu_op_e'(r);
        endcase
    endfunction

    task automatic drive_req(input alu_pkg::alu_op_e op, input alu_pkg::xlen_t a,
                             input alu_pkg::xlen_t b);
        req_i      <= '{op: op, operand_a: a, operand_b: b};
        in_valid_i <= 1'b1;
        @(posedge clk_i);
        while (!in_ready_o) @(posedge clk_i);
        // Occasional idle cycle
        if (($random(seed) & 7) == 0) begin
            in_valid_i <= 1'b0;
            @(posedge clk_i);
        end
    endtask

    // ------------------------------
    // Scoreboard, back-pressure, watchdog
    // ------------------------------
    always @(posedge clk_i) begin : scoreboard
        if (out_valid_o && out_ready_i && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
        end
        if (in_valid_i && in_ready_o) begin
            exp_q.push_back(exp_entry_t'{group: cur_group, rsp: expected_rsp(req_i)});
        end
        exp_count = exp_q.size();
        exp_head  = (exp_count > 0) ? exp_q[0] : '0;
    end

    always @(posedge clk_i) begin : ready_driver
        if (heavy_stall) begin
            out_ready_i <= ($random(ready_seed) & 1) != 0;
        end else begin
            out_ready_i <= ($random(ready_seed) & 3) != 0;
        end
    end

    always @(posedge clk_i) begin : watchdog
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            report_failure($sformatf("Timeout: run not finished after %0d cycles", MAX_CYCLES));
        end
    end

    // ------------------------------
    // Checks
    // ------------------------------
    a_rsp_expected: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        out_valid_o && out_ready_i |-> exp_count > 0)
        else report_failure("A response was delivered with no request outstanding");

    a_rsp_match: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        out_valid_o && out_ready_i && exp_count > 0 |-> rsp_o == exp_head.rsp)
        else report_mismatch($sampled(exp_head), $sampled(rsp_o));

    a_reset_idle: assert property (@(posedge clk_i)
        !rst_n_i |=> !out_valid_o && in_ready_o)
        else report_failure("Output valid high or input not ready after reset");

    a_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        in_valid_i && in_ready_o |=> out_valid_o)
        else report_failure("No response one cycle after an accepted request");

    a_stall_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(rsp_o))
        else report_failure("Stalled response changed or was dropped");

    a_stall_not_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        out_valid_o && !out_ready_i |-> !in_ready_o)
        else report_failure("Input ready high while a response is stalled");

    initial begin : stimulus
        alu_pkg::alu_op_e op;
        alu_pkg::xlen_t   a;
        alu_pkg::xlen_t   b;
        seed        = 32'hc69d_6499;
        ready_seed  = seed ^ 32'h3c3c_3c3c;
        group_name  = '{"arith_logic", "shift", "compare", "polar_sat", "polar_lane",
                        "handshake_mix"};
        cycle_cnt   = 0;
        cur_group   = '0;
        heavy_stall = 1'b0;
        rst_n_i     = 1'b0;
        in_valid_i  = 1'b0;
        out_ready_i = 1'b1;
        req_i       = '0;
        repeat (2) @(posedge clk_i);
        rst_n_i <= 1'b1;
        for (int g = 0; g < NUM_GROUPS; g++) begin
            cur_group   <= 3'(g);
            heavy_stall <= (g == NUM_GROUPS - 1);
            for (int n = 0; n < REQS_PER_GROUP; n++) begin
                op = pick_op(g);
                a  = pick_operand();
                b  = (op inside {[alu_pkg::SLL:alu_pkg::SRAW]}) ? pick_shamt() : pick_operand();
                // Equal operands for the taken side of EQ
                if (g == 2 && ($random(seed) & 3) == 0) begin
                    b = a;
                end
                drive_req(op, a, b);
            end
        end
        in_valid_i <= 1'b0;
        // Let the scoreboard record the last accepted request first
        @(negedge clk_i);
        while (exp_q.size() != 0) @(negedge clk_i);
        @(negedge clk_i);
        if (exp_q.size() == 0 && !out_valid_o) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            report_failure("Responses still outstanding at the end of the run");
        end
    end

endmodule

// ==== verilog/simd_polar_alu.sv ====
// ------------------------------
// Top level of the SIMD polar ALU: request fan-out
// to the datapath and the registered result stage
// ------------------------------

`timescale 1ns/10ps

module simd_polar_alu (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  alu_pkg::alu_req_t req_i,
    input  logic              in_valid_i,
    output logic              in_ready_o,
    output alu_pkg::alu_rsp_t rsp_o,
    output logic              out_valid_o,
    input  logic              out_ready_i
);

    alu_pkg::xlen_t sum;
    alu_pkg::xlen_t b_eff;
    alu_pkg::xlen_t shift_res;
    alu_pkg::word_t shift_res_w;
    alu_pkg::xlen_t polar_res;
    logic           less;
    logic           branch_taken;

    int_adder_cmp i_adder_cmp (
        .op_i           (req_i.op),
        .operand_a_i    (req_i.operand_a),
        .operand_b_i    (req_i.operand_b),
        .sum_o          (sum),
        .b_eff_o        (b_eff),
        .less_o         (less),
        .branch_taken_o (branch_taken)
    );

    // Shift amount is the low bits of operand b
    int_shifter i_shifter (
        .op_i          (req_i.op),
        .operand_a_i   (req_i.operand_a),
        .shamt_i       (req_i.operand_b[$bits(alu_pkg::shamt_t)-1:0]),
        .shift_res_o   (shift_res),
        .shift_res_w_o (shift_res_w)
    );

    polar_simd_unit i_polar (
        .op_i        (req_i.op),
        .operand_a_i (req_i.operand_a),
        .operand_b_i (req_i.operand_b),
        .polar_res_o (polar_res)
    );

    alu_result_stage i_result_stage (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .in_valid_i     (in_valid_i),
        .in_ready_o     (in_ready_o),
        .op_i           (req_i.op),
        .operand_a_i    (req_i.operand_a),
        .sum_i          (sum),
        .b_eff_i        (b_eff),
        .less_i         (less),
        .branch_taken_i (branch_taken),
        .shift_res_i    (shift_res),
        .shift_res_w_i  (shift_res_w),
        .polar_res_i    (polar_res),
        .rsp_o          (rsp_o),
        .out_valid_o    (out_valid_o),
        .out_ready_i    (out_ready_i)
    );

endmodule

// ==== verilog/alu_result_stage.sv ====
// ------------------------------
// Result selection, word sign extension, logic ops
// and the valid/ready output register
// ------------------------------

`timescale 1ns/10ps

module alu_result_stage (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              in_valid_i,
    output logic              in_ready_o,
    input  alu_pkg::alu_op_e  op_i,
    input  alu_pkg::xlen_t    operand_a_i,
    input  alu_pkg::xlen_t    sum_i,
    input  alu_pkg::xlen_t    b_eff_i,
    input  logic              less_i,
    input  logic              branch_taken_i,
    input  alu_pkg::xlen_t    shift_res_i,
    input  alu_pkg::word_t    shift_res_w_i,
    input  alu_pkg::xlen_t    polar_res_i,
    output alu_pkg::alu_rsp_t rsp_o,
    output logic              out_valid_o,
    input  logic              out_ready_i
);

    alu_pkg::alu_rsp_t rsp_d;
    alu_pkg::alu_rsp_t rsp_q;
    logic              valid_q;
    logic              accept;

    // Sign-extend a word result to XLEN
    function automatic alu_pkg::xlen_t sext_word(input alu_pkg::word_t w);
        return {{(alu_pkg::XLEN-alu_pkg::WORD_W){w[alu_pkg::WORD_W-1]}}, w};
    endfunction

    // ------------------------------
    // Result mux
    // ------------------------------
    always_comb begin : result_mux
        rsp_d.branch_taken = branch_taken_i;
        case (op_i)
            alu_pkg::ADD,
            alu_pkg::SUB:  rsp_d.result = sum_i;
            alu_pkg::ADDW,
            alu_pkg::SUBW: rsp_d.result = sext_word(sum_i[alu_pkg::WORD_W-1:0]);

            // b_eff is already inverted for the N forms
            alu_pkg::ANDL,
            alu_pkg::ANDN: rsp_d.result = operand_a_i & b_eff_i;
            alu_pkg::ORL,
            alu_pkg::ORN:  rsp_d.result = operand_a_i | b_eff_i;
            alu_pkg::XORL,
            alu_pkg::XNOR: rsp_d.result = operand_a_i ^ b_eff_i;

            alu_pkg::SLL,
            alu_pkg::SRL,
            alu_pkg::SRA:  rsp_d.result = shift_res_i;
            alu_pkg::SLLW,
            alu_pkg::SRLW,
            alu_pkg::SRAW: rsp_d.result = sext_word(shift_res_w_i);

            alu_pkg::SLTS,
            alu_pkg::SLTU: rsp_d.result = {{(alu_pkg::XLEN-1){1'b0}}, less_i};

            alu_pkg::PL_R,
            alu_pkg::PL_F,
            alu_pkg::PL_SUBSAT,
            alu_pkg::PL_ADDSAT,
            alu_pkg::PL_DECODE,
            alu_pkg::PL_EVAL: rsp_d.result = polar_res_i;

            // Branches only report branch_taken
            default:       rsp_d.result = '0;
        endcase
    end

    // ------------------------------
    // Output register
    // ------------------------------
    assign in_ready_o = ~valid_q | out_ready_i;
    assign accept     = in_valid_i & in_ready_o;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (out_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            rsp_q <= rsp_d;
        end
    end

    assign rsp_o       = rsp_q;
    assign out_valid_o = valid_q;

    // Stalled response must hold until taken
    a_hold_under_stall: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(rsp_o)
    ) else $error("Response changed while stalled");

endmodule

// ==== verilog/polar_simd_unit.sv ====
// ------------------------------
// Polar SIMD unit: eight signed 8-bit lanes,
// lane functions and op selection
// ------------------------------

`timescale 1ns/10ps

module polar_simd_unit (
    input  alu_pkg::alu_op_e op_i,
    input  alu_pkg::xlen_t   operand_a_i,
    input  alu_pkg::xlen_t   operand_b_i,
    output alu_pkg::xlen_t   polar_res_o
);

    // Magnitude, with -128 folded onto 127
    function automatic alu_pkg::lane_t sat_abs(input alu_pkg::lane_t x);
        if (x == {1'b1, {(alu_pkg::LANE_W-1){1'b0}}}) begin
            return alu_pkg::lane_t'(alu_pkg::LANE_SAT_MAX);
        end
        return x[alu_pkg::LANE_W-1] ? -x : x;
    endfunction

    // Clamp a 9-bit lane result to the symmetric range
    function automatic alu_pkg::lane_t sat_clamp(input logic signed [alu_pkg::LANE_W:0] x);
        if (x > alu_pkg::LANE_SAT_MAX) begin
            return alu_pkg::lane_t'(alu_pkg::LANE_SAT_MAX);
        end
        if (x < -alu_pkg::LANE_SAT_MAX) begin
            return alu_pkg::lane_t'(-alu_pkg::LANE_SAT_MAX);
        end
        return x[alu_pkg::LANE_W-1:0];
    endfunction

    // ------------------------------
    // Per-lane datapath
    // ------------------------------
    for (genvar i = 0; i < alu_pkg::NUM_LANES; i++) begin : g_lane
        alu_pkg::lane_t                lane_a;
        alu_pkg::lane_t                lane_b;
        alu_pkg::lane_t                mag_a;
        alu_pkg::lane_t                mag_b;
        alu_pkg::lane_t                mag_min;
        alu_pkg::lane_t                lane_res;
        logic signed [alu_pkg::LANE_W:0] lane_diff;
        logic signed [alu_pkg::LANE_W:0] lane_sum;
        logic                          sign_diff;

        assign lane_a = operand_a_i[i*alu_pkg::LANE_W +: alu_pkg::LANE_W];
        assign lane_b = operand_b_i[i*alu_pkg::LANE_W +: alu_pkg::LANE_W];

        // Nine bits so the sum and difference cannot wrap
        assign lane_diff = $signed(lane_a) - $signed(lane_b);
        assign lane_sum  = $signed(lane_a) + $signed(lane_b);

        assign mag_a     = sat_abs(lane_a);
        assign mag_b     = sat_abs(lane_b);
        assign mag_min   = (mag_a > mag_b) ? mag_b : mag_a;
        assign sign_diff = lane_a[alu_pkg::LANE_W-1] ^ lane_b[alu_pkg::LANE_W-1];

        always_comb begin : lane_sel
            case (op_i)
                alu_pkg::PL_R: begin
                    lane_res = (lane_a[alu_pkg::LANE_W-1] && lane_b != alu_pkg::lane_t'(1))
                             ? alu_pkg::lane_t'(1) : '0;
                end
                alu_pkg::PL_F:      lane_res = sign_diff ? -mag_min : mag_min;
                alu_pkg::PL_SUBSAT: lane_res = sat_clamp(lane_diff);
                alu_pkg::PL_ADDSAT: lane_res = sat_clamp(lane_sum);
                alu_pkg::PL_DECODE: lane_res = (lane_b == '0) ? lane_a : '0;
                alu_pkg::PL_EVAL:   lane_res = (lane_a == alu_pkg::lane_t'(1)) ? '1 : '0;
                default:            lane_res = '0;
            endcase

            if (op_i inside {alu_pkg::PL_SUBSAT, alu_pkg::PL_ADDSAT}) begin
                assert ($signed(lane_res) >= -alu_pkg::LANE_SAT_MAX)
                    else $error("Lane %0d saturated result out of range: %h", i, lane_res);
            end
        end

        assign polar_res_o[i*alu_pkg::LANE_W +: alu_pkg::LANE_W] = lane_res;
    end

endmodule

// ==== verilog/int_shifter.sv ====
// ------------------------------
// 64-bit and 32-bit shifter, left shifts done
// on the right shifter through bit reversal
// ------------------------------

`timescale 1ns/10ps

module int_shifter (
    input  alu_pkg::alu_op_e op_i,
    input  alu_pkg::xlen_t   operand_a_i,
    input  alu_pkg::shamt_t  shamt_i,
    output alu_pkg::xlen_t   shift_res_o,
    output alu_pkg::word_t   shift_res_w_o
);

    logic                     shift_left;
    logic                     shift_arith;

    alu_pkg::xlen_t           a_rev64;
    alu_pkg::word_t           a_rev32;
    alu_pkg::xlen_t           shift_in64;
    alu_pkg::word_t           shift_in32;

    logic [alu_pkg::XLEN:0]   ext64;
    logic [alu_pkg::WORD_W:0] ext32;
    logic [alu_pkg::XLEN:0]   shifted64;
    logic [alu_pkg::WORD_W:0] shifted32;

    alu_pkg::xlen_t           right64;
    alu_pkg::word_t           right32;
    alu_pkg::xlen_t           left64;
    alu_pkg::word_t           left32;

    assign shift_left  = op_i inside {alu_pkg::SLL, alu_pkg::SLLW};
    assign shift_arith = op_i inside {alu_pkg::SRA, alu_pkg::SRAW};

    // Reversed operand feeds the right shifter for left shifts
    assign a_rev64 = {<<{operand_a_i}};
    assign a_rev32 = {<<{operand_a_i[alu_pkg::WORD_W-1:0]}};

    assign shift_in64 = shift_left ? a_rev64 : operand_a_i;
    assign shift_in32 = shift_left ? a_rev32 : operand_a_i[alu_pkg::WORD_W-1:0];

    // Top bit is the fill value, sign only for arithmetic shifts
    assign ext64 = {shift_arith & shift_in64[alu_pkg::XLEN-1], shift_in64};
    assign ext32 = {shift_arith & shift_in32[alu_pkg::WORD_W-1], shift_in32};

    assign shifted64 = $unsigned($signed(ext64) >>> shamt_i);
    // Word forms use the low 5 bits of the amount
    assign shifted32 = $unsigned($signed(ext32) >>> shamt_i[$clog2(alu_pkg::WORD_W)-1:0]);

    assign right64 = shifted64[alu_pkg::XLEN-1:0];
    assign right32 = shifted32[alu_pkg::WORD_W-1:0];

    // Undo the reversal for left shifts
    assign left64 = {<<{right64}};
    assign left32 = {<<{right32}};

    assign shift_res_o   = shift_left ? left64 : right64;
    assign shift_res_w_o = shift_left ? left32 : right32;

endmodule

// ==== verilog/int_adder_cmp.sv ====
// ------------------------------
// Integer adder with operand b inversion,
// signed/unsigned less-than and branch resolution
// ------------------------------

`timescale 1ns/10ps

module int_adder_cmp (
    input  alu_pkg::alu_op_e op_i,
    input  alu_pkg::xlen_t   operand_a_i,
    input  alu_pkg::xlen_t   operand_b_i,
    output alu_pkg::xlen_t   sum_o,
    output alu_pkg::xlen_t   b_eff_o,
    output logic             less_o,
    output logic             branch_taken_o
);

    logic                   negate_b;
    logic [alu_pkg::XLEN:0] adder_ext;
    logic                   zero_flag;
    logic                   is_signed;
    logic                   is_cmp;

    // ------------------------------
    // Adder
    // ------------------------------
    always_comb begin
        case (op_i)
            alu_pkg::EQ,
            alu_pkg::NE,
            alu_pkg::SUB,
            alu_pkg::SUBW,
            alu_pkg::ANDN,
            alu_pkg::ORN,
            alu_pkg::XNOR: negate_b = 1'b1;
            default:       negate_b = 1'b0;
        endcase
    end

    assign b_eff_o = operand_b_i ^ {alu_pkg::XLEN{negate_b}};

    // Extra low bit carries the +1 of the two's complement
    assign adder_ext = {operand_a_i, 1'b1} + {b_eff_o, negate_b};
    assign sum_o     = adder_ext[alu_pkg::XLEN:1];
    assign zero_flag = ~|sum_o;

    // ------------------------------
    // Comparison
    // ------------------------------
    assign is_signed = op_i inside {alu_pkg::SLTS, alu_pkg::LTS, alu_pkg::GES};
    assign is_cmp    = op_i inside {alu_pkg::SLTS, alu_pkg::SLTU,
                                    alu_pkg::LTS,  alu_pkg::LTU,
                                    alu_pkg::GES,  alu_pkg::GEU};

    always_comb begin : less_cmp
        // One extra bit turns the unsigned compare into a signed one
        less_o = $signed({is_signed & operand_a_i[alu_pkg::XLEN-1], operand_a_i})
               < $signed({is_signed & operand_b_i[alu_pkg::XLEN-1], operand_b_i});
        if (is_cmp) begin
            assert (!$isunknown(less_o))
                else $error("less_o undefined for compare op %s", op_i.name());
        end
    end

    // Non-branch ops report taken
    always_comb begin : branch_resolve
        case (op_i)
            alu_pkg::EQ:  branch_taken_o = zero_flag;
            alu_pkg::NE:  branch_taken_o = ~zero_flag;
            alu_pkg::LTS,
            alu_pkg::LTU: branch_taken_o = less_o;
            alu_pkg::GES,
            alu_pkg::GEU: branch_taken_o = ~less_o;
            default:      branch_taken_o = 1'b1;
        endcase
    end

endmodule

// ==== verilog/alu_pkg.sv ====
// ------------------------------
// Shared ALU definitions: widths, polar lane constants,
// operation encoding, request and response structs
// ------------------------------

package alu_pkg;

    // Datapath and lane geometry
    localparam int unsigned XLEN      = 64;
    localparam int unsigned WORD_W    = 32;
    localparam int unsigned LANE_W    = 8;
    localparam int unsigned NUM_LANES = XLEN / LANE_W;

    // Symmetric lane range, negative bound is the negation
    localparam int LANE_SAT_MAX = 127;

    typedef logic [XLEN-1:0]         xlen_t;
    typedef logic [WORD_W-1:0]       word_t;
    typedef logic [LANE_W-1:0]       lane_t;
    typedef logic [$clog2(XLEN)-1:0] shamt_t;

    // ------------------------------
    // Operations
    // ------------------------------
    typedef enum logic [4:0] {
        // Adder
        ADD, SUB, ADDW, SUBW,
        // Logic, with inverted operand b forms
        ANDL, ORL, XORL, ANDN, ORN, XNOR,
        // Shifts
        SLL, SRL, SRA, SLLW, SRLW, SRAW,
        // Set less than
        SLTS, SLTU,
        // Branch resolution
        EQ, NE, LTS, LTU, GES, GEU,
        // Polar lane ops
        PL_R, PL_F, PL_SUBSAT, PL_ADDSAT, PL_DECODE, PL_EVAL
    } alu_op_e;

    // ------------------------------
    // Request and response
    // ------------------------------
    typedef struct packed {
        alu_op_e op;
        xlen_t   operand_a;
        xlen_t   operand_b;
    } alu_req_t;

    typedef struct packed {
        xlen_t result;
        logic  branch_taken;
    } alu_rsp_t;

endpackage
